// File: files.f
rtl/clock_pkg.sv
rtl/button_debounce.sv
rtl/bcd_time_counter.sv
rtl/clock_control.sv
rtl/seg_scan.sv
rtl/alarm_tone.sv
rtl/digital_clock.sv
verification/digital_clock_chk.sv
verification/digital_clock_tb.sv

// File: rtl/alarm_tone.sv
`timescale 1ns/1ps

module alarm_tone #(
        parameter int TONE_HALF_CYCLES = 6250000
) (
        input  logic clk,
        input  logic rst,
        input  logic alarm_active,
        output logic buzzer
);

        localparam int HALF_W = $clog2(TONE_HALF_CYCLES + 1);

        logic [HALF_W-1:0] half_cnt;

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        half_cnt <= '0;
                        buzzer   <= 1'b1; // silent, driver is active low
                end else if (alarm_active) begin
                        if (half_cnt == HALF_W'(TONE_HALF_CYCLES - 1)) begin
                                half_cnt <= '0;
                                buzzer   <= ~buzzer;
                        end else begin
                                half_cnt <= half_cnt + 1'b1;
                        end
                end else begin
                        half_cnt <= '0;
                        buzzer   <= 1'b1;
                end
        end

endmodule

// File: rtl/bcd_time_counter.sv
`timescale 1ns/1ps

module bcd_time_counter (
        input  logic                          clk,
        input  logic                          rst,
        input  logic                          step,
        input  logic [clock_pkg::FIELD_W-1:0] field,
        output clock_pkg::clock_time_t        now
);

        localparam int PAIR_W = 2 * clock_pkg::DIGIT_W;
        localparam logic [PAIR_W-1:0] MS_LAST   = 8'h59;
        localparam logic [PAIR_W-1:0] HOUR_LAST = 8'h23;

        // two-digit bcd increment, wraps to 00 after last
        function automatic logic [PAIR_W-1:0] inc_pair(
                input logic [PAIR_W-1:0] pair,
                input logic [PAIR_W-1:0] last
        );
                logic [clock_pkg::DIGIT_W-1:0] tens;
                logic [clock_pkg::DIGIT_W-1:0] ones;
                tens = pair[PAIR_W-1:clock_pkg::DIGIT_W];
                ones = pair[clock_pkg::DIGIT_W-1:0];
                if (pair == last)
                        return '0;
                if (ones == 4'd9)
                        return {tens + 1'b1, 4'd0};
                return {tens, ones + 1'b1};
        endfunction

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        now <= '0;
                end else if (step) begin
                        case (field)
                                clock_pkg::FIELD_TICK: begin
                                        now.hms.second <= inc_pair(now.hms.second, MS_LAST);
                                        if (now.hms.second == MS_LAST) begin
                                                now.hms.minute <= inc_pair(now.hms.minute,
                                                                           MS_LAST);
                                                if (now.hms.minute == MS_LAST)
                                                        now.hms.hour <= inc_pair(now.hms.hour,
                                                                                 HOUR_LAST);
                                        end
                                end
                                // setting, no carry out of the field
                                clock_pkg::FIELD_SEC: begin
                                        now.hms.second <= inc_pair(now.hms.second, MS_LAST);
                                end
                                clock_pkg::FIELD_MIN: begin
                                        now.hms.minute <= inc_pair(now.hms.minute, MS_LAST);
                                end
                                clock_pkg::FIELD_HOUR: begin
                                        now.hms.hour <= inc_pair(now.hms.hour, HOUR_LAST);
                                end
                                default: begin
                                        now <= now;
                                end
                        endcase
                end
        end

endmodule

// File: rtl/button_debounce.sv
`timescale 1ns/1ps

module button_debounce #(
        parameter int DEBOUNCE_CYCLES = 1000000
) (
        input  logic clk,
        input  logic rst,
        input  logic raw,
        output logic released
);

        localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

        logic sync_a;
        logic sync_b;
        logic level; // filtered key level, high when idle
        logic stable;
        logic [CNT_W-1:0] cnt;

        assign stable = cnt == CNT_W'(DEBOUNCE_CYCLES);

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        sync_a   <= 1'b1;
                        sync_b   <= 1'b1;
                        cnt      <= '0;
                        level    <= 1'b1;
                        released <= 1'b0;
                end else begin
                        sync_a <= raw;
                        sync_b <= sync_a;
                        if (sync_a != sync_b)
                                cnt <= '0; // bounce, start over
                        else if (!stable)
                                cnt <= cnt + 1'b1;
                        if (stable)
                                level <= sync_b;
                        released <= stable & sync_b & ~level; // key let go
                end
        end

endmodule

// File: rtl/clock_control.sv
`timescale 1ns/1ps

module clock_control #(
        parameter int SECOND_CYCLES = 50000000
) (
        input  logic                          clk,
        input  logic                          rst,
        input  logic                          set_pressed,
        input  logic                          alarm_pressed,
        input  logic                          add_pressed,
        input  clock_pkg::clock_time_t        clock_now,
        input  clock_pkg::clock_time_t        alarm_now,
        output logic                          clock_step,
        output logic [clock_pkg::FIELD_W-1:0] clock_field,
        output logic                          alarm_step,
        output logic [clock_pkg::FIELD_W-1:0] alarm_field,
        output clock_pkg::clock_time_t        display_time,
        output logic                          alarm_active,
        output logic                          alarm_on
);

        localparam int PRE_W = $clog2(SECOND_CYCLES + 1);

        logic [clock_pkg::STEP_W-1:0] step;
        logic [PRE_W-1:0] pre_cnt;
        logic running;
        logic tick;
        logic in_alarm_step;

        assign running = step == clock_pkg::STEP_RUN;
        assign tick    = running && pre_cnt == PRE_W'(SECOND_CYCLES - 1);

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        step     <= clock_pkg::STEP_RUN;
                        pre_cnt  <= '0;
                        alarm_on <= 1'b0;
                end else begin
                        if (set_pressed && !add_pressed)
                                step <= (step == clock_pkg::STEP_ALM_HOUR) ?
                                        clock_pkg::STEP_RUN : step + 1'b1;
                        if (running)
                                pre_cnt <= tick ? '0 : pre_cnt + 1'b1; // frozen while setting
                        if (alarm_pressed)
                                alarm_on <= ~alarm_on;
                end
        end

        // add presses go to the field of the current step
        always_comb begin
                clock_step    = 1'b0;
                clock_field   = clock_pkg::FIELD_TICK;
                alarm_step    = 1'b0;
                alarm_field   = clock_pkg::FIELD_SEC;
                in_alarm_step = 1'b0;
                case (step)
                        clock_pkg::STEP_RUN: clock_step = tick;
                        clock_pkg::STEP_SET_SEC: begin
                                clock_step  = add_pressed;
                                clock_field = clock_pkg::FIELD_SEC;
                        end
                        clock_pkg::STEP_SET_MIN: begin
                                clock_step  = add_pressed;
                                clock_field = clock_pkg::FIELD_MIN;
                        end
                        clock_pkg::STEP_SET_HOUR: begin
                                clock_step  = add_pressed;
                                clock_field = clock_pkg::FIELD_HOUR;
                        end
                        clock_pkg::STEP_ALM_SEC: begin
                                alarm_step    = add_pressed;
                                in_alarm_step = 1'b1;
                        end
                        clock_pkg::STEP_ALM_MIN: begin
                                alarm_step    = add_pressed;
                                alarm_field   = clock_pkg::FIELD_MIN;
                                in_alarm_step = 1'b1;
                        end
                        clock_pkg::STEP_ALM_HOUR: begin
                                alarm_step    = add_pressed;
                                alarm_field   = clock_pkg::FIELD_HOUR;
                                in_alarm_step = 1'b1;
                        end
                        default: ;
                endcase
        end

        assign display_time = in_alarm_step ? alarm_now : clock_now;
        assign alarm_active = alarm_on && running && (clock_now == alarm_now);

endmodule

// File: rtl/clock_pkg.sv
package clock_pkg;

        localparam int DIGIT_W = 4;
        localparam int DIGITS  = 6;
        localparam int SEG_W   = 8; // a..g plus dot, active low

        localparam int STEP_W = 3;
        localparam logic [STEP_W-1:0] STEP_RUN      = 3'd0;
        localparam logic [STEP_W-1:0] STEP_SET_SEC  = 3'd1;
        localparam logic [STEP_W-1:0] STEP_SET_MIN  = 3'd2;
        localparam logic [STEP_W-1:0] STEP_SET_HOUR = 3'd3;
        localparam logic [STEP_W-1:0] STEP_ALM_SEC  = 3'd4;
        localparam logic [STEP_W-1:0] STEP_ALM_MIN  = 3'd5;
        localparam logic [STEP_W-1:0] STEP_ALM_HOUR = 3'd6;

        localparam int FIELD_W = 2;
        localparam logic [FIELD_W-1:0] FIELD_TICK = 2'd0; // one second, full carry
        localparam logic [FIELD_W-1:0] FIELD_SEC  = 2'd1;
        localparam logic [FIELD_W-1:0] FIELD_MIN  = 2'd2;
        localparam logic [FIELD_W-1:0] FIELD_HOUR = 2'd3;

        // same 24 bits seen as hh:mm:ss or as six display digits
        typedef union packed {
                struct packed {
                        logic [1:0][DIGIT_W-1:0] hour;   // [1] is the tens digit
                        logic [1:0][DIGIT_W-1:0] minute;
                        logic [1:0][DIGIT_W-1:0] second;
                } hms;
                logic [0:DIGITS-1][DIGIT_W-1:0] digit; // digit 0 = hour tens
        } clock_time_t;

endpackage

// File: rtl/digital_clock.sv
`timescale 1ns/1ps

module digital_clock #(
        parameter int SECOND_CYCLES    = 50000000,
        parameter int DEBOUNCE_CYCLES  = 1000000,
        parameter int SCAN_CYCLES      = 41667,
        parameter int TONE_HALF_CYCLES = 6250000
) (
        input  logic       clk,
        input  logic       rst,
        input  logic       set_button,
        input  logic       alarm_button,
        input  logic       add_button,
        output logic       buzzer,
        output logic [5:0] seg_sel,
        output logic [7:0] seg_data,
        output logic       alarm_led
);

        logic set_pressed;
        logic alarm_pressed;
        logic add_pressed;
        logic clock_step;
        logic alarm_step;
        logic alarm_active;
        logic [clock_pkg::FIELD_W-1:0] clock_field;
        logic [clock_pkg::FIELD_W-1:0] alarm_field;
        clock_pkg::clock_time_t clock_now;
        clock_pkg::clock_time_t alarm_now;
        clock_pkg::clock_time_t display_time;

        button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) set_debounce (
                .clk(clk), .rst(rst), .raw(set_button), .released(set_pressed));
        button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) alarm_debounce (
                .clk(clk), .rst(rst), .raw(alarm_button), .released(alarm_pressed));
        button_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) add_debounce (
                .clk(clk), .rst(rst), .raw(add_button), .released(add_pressed));

        clock_control #(.SECOND_CYCLES(SECOND_CYCLES)) control (
                .clk(clk), .rst(rst),
                .set_pressed(set_pressed), .alarm_pressed(alarm_pressed),
                .add_pressed(add_pressed),
                .clock_now(clock_now), .alarm_now(alarm_now),
                .clock_step(clock_step), .clock_field(clock_field),
                .alarm_step(alarm_step), .alarm_field(alarm_field),
                .display_time(display_time), .alarm_active(alarm_active),
                .alarm_on(alarm_led));

        bcd_time_counter running_time (
                .clk(clk), .rst(rst), .step(clock_step), .field(clock_field), .now(clock_now));
        bcd_time_counter alarm_time (
                .clk(clk), .rst(rst), .step(alarm_step), .field(alarm_field), .now(alarm_now));

        seg_scan #(.SCAN_CYCLES(SCAN_CYCLES)) scan (
                .clk(clk), .rst(rst), .display_time(display_time),
                .seg_sel(seg_sel), .seg_data(seg_data));

        alarm_tone #(.TONE_HALF_CYCLES(TONE_HALF_CYCLES)) tone (
                .clk(clk), .rst(rst), .alarm_active(alarm_active), .buzzer(buzzer));

endmodule

// File: rtl/seg_scan.sv
`timescale 1ns/1ps

module seg_scan #(
        parameter int SCAN_CYCLES = 41667
) (
        input  logic                          clk,
        input  logic                          rst,
        input  clock_pkg::clock_time_t        display_time,
        output logic [clock_pkg::DIGITS-1:0]  seg_sel,
        output logic [clock_pkg::SEG_W-1:0]   seg_data
);

        localparam int SCAN_W = $clog2(SCAN_CYCLES + 1);
        localparam int IDX_W  = $clog2(clock_pkg::DIGITS);

        logic [SCAN_W-1:0] scan_cnt;
        logic [IDX_W-1:0] idx;
        logic scan_step;

        // segments g..a, low lights the segment
        function automatic logic [6:0] hex_seg(input logic [clock_pkg::DIGIT_W-1:0] d);
                case (d)
                        4'h0: return 7'b100_0000;
                        4'h1: return 7'b111_1001;
                        4'h2: return 7'b010_0100;
                        4'h3: return 7'b011_0000;
                        4'h4: return 7'b001_1001;
                        4'h5: return 7'b001_0010;
                        4'h6: return 7'b000_0010;
                        4'h7: return 7'b111_1000;
                        4'h8: return 7'b000_0000;
                        4'h9: return 7'b001_0000;
                        4'ha: return 7'b000_1000;
                        4'hb: return 7'b000_0011;
                        4'hc: return 7'b100_0110;
                        4'hd: return 7'b010_0001;
                        4'he: return 7'b000_0110;
                        default: return 7'b000_1110;
                endcase
        endfunction

        assign scan_step = scan_cnt == SCAN_W'(SCAN_CYCLES - 1);

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        scan_cnt <= '0;
                        idx      <= '0;
                        seg_sel  <= '1; // all digits off
                        seg_data <= '1;
                end else begin
                        scan_cnt <= scan_step ? '0 : scan_cnt + 1'b1;
                        if (scan_step) begin
                                idx      <= (idx == IDX_W'(clock_pkg::DIGITS - 1)) ?
                                            '0 : idx + 1'b1;
                                seg_sel  <= ~(clock_pkg::DIGITS'(1) << idx);
                                // odd digits carry the dot
                                seg_data <= {~idx[0], hex_seg(display_time.digit[idx])};
                        end
                end
        end

endmodule

// File: run.sh
#!/bin/sh
# build and run the digital_clock testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f files.f \
        --top-module digital_clock_tb -o digital_clock_sim; then
        echo "verilator build failed"
        exit 1
fi

if ! ./obj_dir/digital_clock_sim > "$log" 2>&1; then
        cat "$log"
        echo "simulation exited with an error"
        exit 1
fi
cat "$log"

if grep -q "^STATUS: PASS$" "$log"; then
        exit 0
fi
exit 1

// File: verification/digital_clock_chk.sv
`timescale 1ns/1ps

module digital_clock_chk (
        input logic       clk,
        input logic       rst,
        input logic       buzzer,
        input logic [5:0] seg_sel,
        input logic [7:0] seg_data,
        input logic       alarm_led
);

        // scan never lights two digits at once
        one_digit: assert property (@(posedge clk) disable iff (!rst)
                $countones(~seg_sel) <= 1)
                else $error("more than one digit selected");

        // tone releases the buzzer one edge after the enable drops
        quiet_when_off: assert property (@(posedge clk) disable iff (!rst)
                !alarm_led && !$past(alarm_led) |-> buzzer)
                else $error("buzzer sounding with the alarm disabled");

        blank_when_idle: assert property (@(posedge clk) disable iff (!rst)
                &seg_sel |-> seg_data == 8'hff)
                else $error("segments driven with no digit selected");

endmodule

bind digital_clock digital_clock_chk chk (
        .clk(clk), .rst(rst), .buzzer(buzzer), .seg_sel(seg_sel),
        .seg_data(seg_data), .alarm_led(alarm_led));

// File: verification/digital_clock_tb.sv
`timescale 1ns/1ps

module digital_clock_tb;

        localparam int ROWS       = 13;
        localparam int SCAN_LIMIT = 60; // cycles allowed per digit select
        localparam logic [1:0] ACT_NONE  = 2'd0;
        localparam logic [1:0] ACT_SET   = 2'd1;
        localparam logic [1:0] ACT_ADD   = 2'd2;
        localparam logic [1:0] ACT_ALARM = 2'd3;

        typedef struct packed {
                logic [1:0]  action;
                logic [7:0]  count;
                logic        hm_only;  // seconds may tick before the read
                logic [23:0] time_bcd; // hhmmss
                logic        led;
        } row_t;

        logic clk;
        logic rst;
        logic set_button;
        logic alarm_button;
        logic add_button;
        logic buzzer;
        logic [5:0] seg_sel;
        logic [7:0] seg_data;
        logic alarm_led;

        // gfedcba, low lights the segment
        logic [6:0] seg_table [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                       7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

        row_t rows [ROWS] = '{
                '{ACT_SET,   8'd1,  1'b0, 24'h000000, 1'b0},
                '{ACT_ADD,   8'd58, 1'b0, 24'h000058, 1'b0},
                '{ACT_SET,   8'd1,  1'b0, 24'h000058, 1'b0},
                '{ACT_ADD,   8'd59, 1'b0, 24'h005958, 1'b0},
                '{ACT_ADD,   8'd1,  1'b0, 24'h000058, 1'b0}, // minutes wrap, hours untouched
                '{ACT_ADD,   8'd59, 1'b0, 24'h005958, 1'b0},
                '{ACT_SET,   8'd1,  1'b0, 24'h005958, 1'b0},
                '{ACT_ADD,   8'd23, 1'b0, 24'h235958, 1'b0},
                '{ACT_SET,   8'd1,  1'b0, 24'h000000, 1'b0}, // alarm time on display
                '{ACT_ADD,   8'd1,  1'b0, 24'h000001, 1'b0},
                '{ACT_SET,   8'd2,  1'b0, 24'h000001, 1'b0},
                '{ACT_ALARM, 8'd1,  1'b0, 24'h000001, 1'b1},
                '{ACT_SET,   8'd1,  1'b1, 24'h235958, 1'b1}};
        string names [ROWS] = '{"set_sec_step", "add_sec_58", "set_min_step", "add_min_59",
                                "add_min_wrap", "add_min_restore", "set_hour_step",
                                "add_hour_23", "set_alm_sec_step", "add_alm_sec_1",
                                "set_alm_hour_step", "alarm_enable", "set_run_step"};

        clock_pkg::clock_time_t shown;
        int r;
        int n;

        digital_clock #(
                .SECOND_CYCLES(40),
                .DEBOUNCE_CYCLES(4),
                .SCAN_CYCLES(3),
                .TONE_HALF_CYCLES(2)
        ) uut (
                .clk(clk), .rst(rst), .set_button(set_button), .alarm_button(alarm_button),
                .add_button(add_button), .buzzer(buzzer), .seg_sel(seg_sel),
                .seg_data(seg_data), .alarm_led(alarm_led));

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        task automatic report_failure(input string what);
                $display("%s", what);
                $display("STATUS: FAIL");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic compare(input string name, input logic [23:0] expected,
                               input logic [23:0] actual);
                if (actual !== expected)
                        report_failure($sformatf("** Error %s: expected %h, actual %h",
                                                 name, expected, actual));
        endtask

        task automatic next_sample(inout int waited, input int limit, input string what);
                @(negedge clk);
                waited++;
                if (waited > limit)
                        report_failure($sformatf("timed out waiting for %s", what));
        endtask

        // key down 10 cycles, up 10 cycles, so the release pulse lands inside
        task automatic press(input logic [1:0] action);
                @(posedge clk);
                #2;
                case (action)
                        ACT_SET:   set_button = 1'b0;
                        ACT_ADD:   add_button = 1'b0;
                        ACT_ALARM: alarm_button = 1'b0;
                        default: ;
                endcase
                repeat (10) @(posedge clk);
                #2;
                set_button   = 1'b1;
                add_button   = 1'b1;
                alarm_button = 1'b1;
                repeat (10) @(posedge clk);
                #2;
        endtask

        task automatic read_display(input string name, output clock_pkg::clock_time_t t);
                logic [5:0] pat;
                logic [3:0] d;
                logic found;
                int waited;
                int i;
                int v;
                t = '0;
                for (i = 0; i < clock_pkg::DIGITS; i++) begin
                        pat = ~(6'd1 << i);
                        waited = 0;
                        while (i == 0 && seg_sel == pat) // want a freshly latched digit 0
                                next_sample(waited, SCAN_LIMIT, "the scan to leave digit 0");
                        while (seg_sel != pat)
                                next_sample(waited, SCAN_LIMIT,
                                            $sformatf("digit %0d to be selected", i));
                        d = 4'd0;
                        found = 1'b0;
                        for (v = 0; v < 16; v++) begin
                                if (seg_table[v] == seg_data[6:0]) begin
                                        d = 4'(v);
                                        found = 1'b1;
                                end
                        end
                        if (!found)
                                report_failure($sformatf("%s: digit %0d shows no hex character",
                                                         name, i));
                        compare($sformatf("%s dot %0d", name, i), 24'(i % 2 == 0),
                                24'(seg_data[7]));
                        t.digit[i] = d;
                end
        endtask

        // keeps reading until target shows, starting from the last read
        task automatic wait_for_time(input string name, input logic [23:0] target,
                                     inout clock_pkg::clock_time_t t);
                int reads;
                reads = 0;
                while (t !== target) begin
                        reads++;
                        if (reads > 30)
                                report_failure($sformatf("timed out waiting for display %h",
                                                         target));
                        read_display(name, t);
                end
        endtask

        initial begin
                rst          = 1'b0;
                set_button   = 1'b1;
                alarm_button = 1'b1;
                add_button   = 1'b1;
                repeat (5) @(posedge clk);
                #2;
                rst = 1'b1;
                compare("reset_seg_sel", 24'h00003f, 24'(seg_sel));
                compare("reset_seg_data", 24'h0000ff, 24'(seg_data));
                compare("reset_buzzer", 24'd1, 24'(buzzer));
                compare("reset_alarm_led", 24'd0, 24'(alarm_led));
                read_display("first_scan", shown);
                compare("first_scan", 24'h000000, shown);

                for (r = 0; r < ROWS; r++) begin
                        if (rows[r].action != ACT_NONE) begin
                                for (n = 0; n < int'(rows[r].count); n++)
                                        press(rows[r].action);
                        end
                        read_display(names[r], shown);
                        if (rows[r].hm_only)
                                compare(names[r], rows[r].time_bcd & 24'hffff00,
                                        shown & 24'hffff00);
                        else
                                compare(names[r], rows[r].time_bcd, shown);
                        compare({names[r], "_led"}, 24'(rows[r].led), 24'(alarm_led));
                end

                wait_for_time("run_to_235959", 24'h235959, shown);
                wait_for_time("run_to_000000", 24'h000000, shown); // full carry into the hours
                n = 0;
                while (buzzer !== 1'b0)
                        next_sample(n, 200, "the buzzer to sound at 00:00:01");
                read_display("alarm_match_time", shown);
                compare("alarm_match_time", 24'h000001, shown);
                wait_for_time("after_alarm", 24'h000002, shown);
                repeat (20) begin
                        @(negedge clk);
                        compare("buzzer_quiet", 24'd1, 24'(buzzer));
                end
                press(ACT_ALARM);
                compare("alarm_disable_led", 24'd0, 24'(alarm_led));

                $display("STATUS: PASS");
                $finish;
        end

endmodule
